// File: common/tmds_pkg.sv
/* shared TMDS symbol types, sync control codes and the TERC4 code table
 */
package tmds_pkg;

	// one TMDS symbol on the wire
	localparam int WORD_BITS = 10;

	// bit offsets a symbol can start at within two raw words
	localparam int PHASE_COUNT = 10;

	// raw or aligned 10-bit symbol
	typedef logic [WORD_BITS-1:0] tmds_word_t;

	// decoded 8-bit channel value
	typedef logic [7:0] pixel_t;

	// hsync/vsync pair carried by the control periods
	typedef logic [1:0] sync_t;

	// data island nibble
	typedef logic [3:0] terc4_t;

	// 0 to PHASE_COUNT-1
	typedef logic [3:0] phase_t;

	// control period symbols, one per hsync/vsync combination
	localparam tmds_word_t CTRL_00 = 10'b1101010100;
	localparam tmds_word_t CTRL_01 = 10'b0010101011;
	localparam tmds_word_t CTRL_10 = 10'b0101010100;
	// CTRL_11 is also the symbol used for word alignment
	localparam tmds_word_t CTRL_11 = 10'b1010101011;

	// TERC4 symbols, entry n encodes nibble n
	localparam tmds_word_t TERC4_CODES [16] = '{
		10'b1010011100,
		10'b1001100011,
		10'b1011100100,
		10'b1011100010,
		10'b0101110001,
		10'b0100011110,
		10'b0110001110,
		10'b0100111100,
		10'b1011001100,
		10'b0100111001,
		10'b0110011100,
		10'b1011000110,
		10'b1010001110,
		10'b1001110001,
		10'b0101100011,
		10'b1011000011
	};

endpackage

// File: common/tmds_word_if.sv
/* one aligned three-channel TMDS symbol set with its strobe
 */
`timescale 1ns/10ps

interface tmds_word_if;
	import tmds_pkg::*;

	// single-cycle strobe, the channels only mean something while it is high
	logic valid;

	// channel 0 carries sync and TERC4, 1 and 2 carry pixel data
	tmds_word_t ch0;
	tmds_word_t ch1;
	tmds_word_t ch2;

	modport source (
		output valid, ch0, ch1, ch2
	);

	modport sink (
		input valid, ch0, ch1, ch2
	);

endinterface

// File: design/tmds_word_aligner.sv
/* per-channel raw word history and phase-selected symbol extraction
 */
`timescale 1ns/10ps

module tmds_word_aligner (
	input logic hdmi_clk,
	input logic reset,
	input logic in_valid,
	input tmds_pkg::tmds_word_t d0_in,
	input tmds_pkg::tmds_word_t d1_in,
	input tmds_pkg::tmds_word_t d2_in,
	input tmds_pkg::phase_t phase,
	tmds_word_if.source aligned
);
	import tmds_pkg::*;

	// raw word from the previous strobe of each channel
	tmds_word_t prev0;
	tmds_word_t prev1;
	tmds_word_t prev2;

	// previous word sits in the upper half, the newest word in the lower half
	// phase 0 hands back the newest word unchanged
	function automatic tmds_word_t extract(tmds_word_t older, tmds_word_t newer, phase_t ph);
		logic [2*WORD_BITS-1:0] history;
		history = {older, newer};
		return history[ph +: WORD_BITS];
	endfunction

	// strobe follows in_valid by one cycle
	always_ff @(posedge hdmi_clk or posedge reset)
	begin
		if (reset)
			aligned.valid <= 1'b0;
		else
			aligned.valid <= in_valid;
	end

	// history and window only move on a strobe
	always_ff @(posedge hdmi_clk)
	begin
		if (in_valid)
		begin
			prev0 <= d0_in;
			prev1 <= d1_in;
			prev2 <= d2_in;
			aligned.ch0 <= extract(prev0, d0_in, phase);
			aligned.ch1 <= extract(prev1, d1_in, phase);
			aligned.ch2 <= extract(prev2, d2_in, phase);
		end
	end

	// the recognizer must never hand over a phase past the last bit offset
	assert property (@(posedge hdmi_clk) disable iff (reset) phase < PHASE_COUNT)
		else $error("aligner phase %0d out of range", phase);

endmodule

// File: design/tmds_sync_recognizer.sv
/* CTRL_11 pair detection on channel 0, bit phase stepping and lock timeout
 */
`timescale 1ns/10ps

module tmds_sync_recognizer #(
	parameter int LOCK_TIMEOUT_BITS = 22
) (
	input logic hdmi_clk,
	input logic reset,
	input logic phase_step,
	tmds_word_if.sink aligned,
	output tmds_pkg::phase_t phase,
	output logic locked
);
	import tmds_pkg::*;

	typedef enum logic [1:0] {
		HUNT,
		CONFIRM,
		LOCKED
	} state_t;

	state_t state;

	// aligned strobes since the last CTRL_11 pair
	logic [LOCK_TIMEOUT_BITS-1:0] timeout_cnt;

	// previous aligned channel-0 symbol was CTRL_11
	logic prev_ctrl11;

	logic is_ctrl11;
	logic is_pair;
	logic drop_lock;
	logic step_ok;

	assign is_ctrl11 = aligned.valid && (aligned.ch0 == CTRL_11);
	assign is_pair = is_ctrl11 && prev_ctrl11;

	// counter would reach 2**LOCK_TIMEOUT_BITS on this strobe
	assign drop_lock = aligned.valid && (state == LOCKED) && !is_pair && (&timeout_cnt);

	// no stepping once locked, nor while a CTRL_11 is showing at the current phase
	assign step_ok = phase_step && (state != LOCKED) && !is_ctrl11;

	always_ff @(posedge hdmi_clk or posedge reset)
	begin
		if (reset)
		begin
			state <= HUNT;
			locked <= 1'b0;
			phase <= '0;
			timeout_cnt <= '0;
			prev_ctrl11 <= 1'b0;
		end
		else
		begin
			if (aligned.valid)
			begin
				prev_ctrl11 <= is_ctrl11;
				case (state)
				HUNT:
					if (is_ctrl11)
						state <= CONFIRM;
				CONFIRM:
				begin
					// second CTRL_11 in a row means the words are aligned
					if (is_ctrl11)
						state <= LOCKED;
					else
						state <= HUNT;
					timeout_cnt <= '0;
				end
				default:
				begin
					if (is_pair)
						timeout_cnt <= '0;
					else if (drop_lock)
					begin
						// sync lost, start hunting from the current phase
						state <= HUNT;
						timeout_cnt <= '0;
					end
					else
						timeout_cnt <= timeout_cnt + 1'b1;
				end
				endcase
			end

			// lock output trails the state by one cycle but drops together with it
			locked <= (state == LOCKED) && !drop_lock;

			if (step_ok)
			begin
				if (phase == phase_t'(PHASE_COUNT - 1))
					phase <= '0;
				else
					phase <= phase + 1'b1;
			end
		end
	end

	// hdmi_valid can only be seen while the FSM sits in LOCKED
	assert property (@(posedge hdmi_clk) disable iff (reset) locked |-> state == LOCKED)
		else $error("locked without LOCKED state");

endmodule

// File: design/tmds_symbol_decoder.sv
/* TMDS 10b to 8b decode and sync, TERC4 or data classification of one channel
 */
`timescale 1ns/10ps

module tmds_symbol_decoder (
	input logic hdmi_clk,
	input logic reset,
	input logic symbol_valid,
	input tmds_pkg::tmds_word_t symbol,
	output logic data_valid,
	output logic sync_valid,
	output logic ctrl_valid,
	output tmds_pkg::pixel_t data,
	output tmds_pkg::sync_t sync,
	output tmds_pkg::terc4_t ctrl
);
	import tmds_pkg::*;

	pixel_t bits;
	pixel_t decoded;
	logic is_sync;
	logic is_terc4;
	sync_t sync_code;
	terc4_t terc4_code;

	// bit 9 says the data bits were inverted, bit 8 picks xor over xnor
	always_comb
	begin
		bits = symbol[WORD_BITS-1] ? ~symbol[7:0] : symbol[7:0];
		// lowest bit went out as is
		decoded[0] = bits[0];
		for (int i = 1; i < 8; i++)
		begin
			if (symbol[WORD_BITS-2])
				decoded[i] = bits[i] ^ bits[i-1];
			else
				decoded[i] = ~(bits[i] ^ bits[i-1]);
		end
	end

	// control period symbols
	always_comb
	begin
		is_sync = 1'b1;
		sync_code = '0;
		case (symbol)
		CTRL_00: sync_code = 2'b00;
		CTRL_01: sync_code = 2'b01;
		CTRL_10: sync_code = 2'b10;
		CTRL_11: sync_code = 2'b11;
		default: is_sync = 1'b0;
		endcase
	end

	// data island symbols whose table index is the nibble
	always_comb
	begin
		is_terc4 = 1'b0;
		terc4_code = '0;
		for (int n = 0; n < 16; n++)
		begin
			if (symbol == TERC4_CODES[n])
			begin
				is_terc4 = 1'b1;
				terc4_code = terc4_t'(n);
			end
		end
	end

	// one class strobe per symbol
	always_ff @(posedge hdmi_clk or posedge reset)
	begin
		if (reset)
		begin
			data_valid <= 1'b0;
			sync_valid <= 1'b0;
			ctrl_valid <= 1'b0;
		end
		else
		begin
			data_valid <= symbol_valid && !is_sync && !is_terc4;
			sync_valid <= symbol_valid && is_sync;
			ctrl_valid <= symbol_valid && is_terc4;
		end
	end

	// values hold between strobes
	always_ff @(posedge hdmi_clk)
	begin
		if (symbol_valid)
		begin
			data <= decoded;
			if (is_sync)
				sync <= sync_code;
			if (is_terc4)
				ctrl <= terc4_code;
		end
	end

	assert property (@(posedge hdmi_clk) disable iff (reset)
		$onehot0({data_valid, sync_valid, ctrl_valid}))
		else $error("more than one class strobe");

endmodule

// File: design/tmds_decoder.sv
/* HDMI TMDS receive decoder top: word aligner, sync recognizer, three channel decoders
 */
`timescale 1ns/10ps

module tmds_decoder #(
	parameter int LOCK_TIMEOUT_BITS = 22
) (
	input logic hdmi_clk,
	input logic reset,
	input logic in_valid,
	input logic phase_step,
	input tmds_pkg::tmds_word_t d0_in,
	input tmds_pkg::tmds_word_t d1_in,
	input tmds_pkg::tmds_word_t d2_in,
	output logic hdmi_valid,
	output logic data_valid,
	output tmds_pkg::pixel_t d0,
	output tmds_pkg::pixel_t d1,
	output tmds_pkg::pixel_t d2,
	output logic sync_valid,
	output tmds_pkg::sync_t sync,
	output logic ctrl_valid,
	output tmds_pkg::terc4_t ctrl
);
	import tmds_pkg::*;

	// bit offset chosen by the recognizer
	phase_t phase;

	// aligned symbols, one cycle behind in_valid
	tmds_word_if aligned_word ();

	tmds_word_aligner i_aligner (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.in_valid(in_valid),
		.d0_in(d0_in),
		.d1_in(d1_in),
		.d2_in(d2_in),
		.phase(phase),
		.aligned(aligned_word.source)
	);

	// only channel 0 carries the CTRL symbols used for alignment
	tmds_sync_recognizer #(
		.LOCK_TIMEOUT_BITS(LOCK_TIMEOUT_BITS)
	) i_recognizer (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.phase_step(phase_step),
		.aligned(aligned_word.sink),
		.phase(phase),
		.locked(hdmi_valid)
	);

	// channel 0 decides the class for the whole symbol set
	tmds_symbol_decoder i_decoder_0 (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.symbol_valid(aligned_word.valid),
		.symbol(aligned_word.ch0),
		.data_valid(data_valid),
		.sync_valid(sync_valid),
		.ctrl_valid(ctrl_valid),
		.data(d0),
		.sync(sync),
		.ctrl(ctrl)
	);

	// audio islands on channels 1 and 2 are not handled, only pixel data is used
	tmds_symbol_decoder i_decoder_1 (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.symbol_valid(aligned_word.valid),
		.symbol(aligned_word.ch1),
		.data_valid(),
		.sync_valid(),
		.ctrl_valid(),
		.data(d1),
		.sync(),
		.ctrl()
	);

	tmds_symbol_decoder i_decoder_2 (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.symbol_valid(aligned_word.valid),
		.symbol(aligned_word.ch2),
		.data_valid(),
		.sync_valid(),
		.ctrl_valid(),
		.data(d2),
		.sync(),
		.ctrl()
	);

endmodule

// File: verif/tmds_tests.svh
/* directed tests: reset state, lock at phase 0, pixel decode, code classification,
 * alignment hunt with a bit slip, and lock loss after the timeout */
`ifndef TMDS_TESTS_SVH
`define TMDS_TESTS_SVH

	// nothing may come out while idle after reset
	task automatic check_reset_state();
		for (int i = 0; i < 6; i++)
		begin
			@(negedge hdmi_clk);
			if (hdmi_valid !== 1'b0)
				value_error("hdmi_valid", hdmi_valid, 0);
			if ({data_valid, sync_valid, ctrl_valid} !== 3'b000)
				value_error("{data_valid,sync_valid,ctrl_valid}",
					{data_valid, sync_valid, ctrl_valid}, 0);
		end
	endtask

	// two CTRL_11 symbols lock, hdmi_valid three cycles after the second strobe
	task automatic lock_at_phase_zero();
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(2);
		if (hdmi_valid !== 1'b0)
			value_error("hdmi_valid", hdmi_valid, 0);
		idle(1);
		if (hdmi_valid !== 1'b1)
			value_error("hdmi_valid", hdmi_valid, 1);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(3);
	endtask

	task automatic pixel_decode();
		for (int i = 0; i < 40; i++)
		begin
			send_pixel();
			// every third strobe is followed directly by the next one
			if (i % 3 != 2)
				idle(1);
		end
		idle(3);
		// 40 strobes stay well inside the lock timeout
		if (hdmi_valid !== 1'b1)
			value_error("hdmi_valid", hdmi_valid, 1);
	endtask

	task automatic classify_codes();
		// pair first so the lock counter restarts
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_00, CTRL_00, CTRL_00, KIND_SYNC, 0, 0, 0);
		send_stream(CTRL_01, CTRL_01, CTRL_01, KIND_SYNC, 1, 0, 0);
		send_stream(CTRL_10, CTRL_10, CTRL_10, KIND_SYNC, 2, 0, 0);
		idle(1);
		for (int n = 0; n < 16; n++)
		begin
			send_stream(TERC4_CODES[n], TERC4_CODES[n], TERC4_CODES[n], KIND_CTRL, n, 0, 0);
			idle(1);
		end
		idle(3);
	endtask

	task automatic alignment_hunt();
		int steps;
		int slip;
		// run the old lock out with pixel data
		for (int i = 0; i < LOCK_STROBES; i++)
		begin
			send_pixel();
			idle(1);
		end
		idle(3);
		if (hdmi_valid !== 1'b0)
			value_error("hdmi_valid", hdmi_valid, 0);
		// symbol boundary now sits slip bits into each raw word
		slip = 1 + int'(lcg_next() % 9);
		bit_slip = slip;
		hunting = 1'b1;
		steps = 0;
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(3);
		while (!hdmi_valid && steps < 10)
		begin
			pulse_phase_step();
			steps++;
			send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
			send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
			idle(3);
		end
		hunting = 1'b0;
		if (!hdmi_valid)
			failure($sformatf("no lock after 10 phase steps, slip %0d", slip));
		else if (steps != 10 - slip)
			failure($sformatf("locked after %0d phase steps, slip %0d needs %0d",
				steps, slip, 10 - slip));
		for (int i = 0; i < 12; i++)
		begin
			send_pixel();
			idle(1);
		end
		// one more word completes the last pixel
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(3);
	endtask

	// counts are in aligned strobes, the first CTRL_11 of a pair is a non-pair strobe
	task automatic lock_loss();
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(3);
		if (hdmi_valid !== 1'b1)
			value_error("hdmi_valid", hdmi_valid, 1);
		// 62 pixels plus the next CTRL_11 make 63 strobes without a pair
		for (int i = 0; i < LOCK_STROBES - 2; i++)
			send_pixel();
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		send_stream(CTRL_11, CTRL_11, CTRL_11, KIND_SYNC, 3, 0, 0);
		idle(3);
		if (hdmi_valid !== 1'b1)
			value_error("hdmi_valid", hdmi_valid, 1);
		// one extra pixel pushes the 64th through a slipped stream too
		for (int i = 0; i < LOCK_STROBES + 1; i++)
			send_pixel();
		idle(3);
		if (hdmi_valid !== 1'b0)
			value_error("hdmi_valid", hdmi_valid, 0);
	endtask

`endif

// File: verif/tmds_decoder_tb.sv
/* testbench for the TMDS decoder: clock, reset, DUT, LCG, TMDS encoder model,
 * output scoreboard, cycle timeout and the closing result line */
`timescale 1ns/10ps

module tmds_decoder_tb;
	import tmds_pkg::*;

	localparam int LOCK_TIMEOUT_BITS = 6;
	// non-pair strobes that drop the lock
	localparam int LOCK_STROBES = 2 ** LOCK_TIMEOUT_BITS;
	// fixed bursts of tests 2 to 6 plus three bursts sized by the lock timeout
	localparam int TEST_STROBES = 4 + 40 + 21 + 13 + 4;
	localparam int LOCK_WAITS = 3;
	localparam int HUNT_CYCLES = 7 * (PHASE_COUNT + 1);
	localparam int MAX_CYCLES = 8 + 2 * (TEST_STROBES + LOCK_WAITS * (LOCK_STROBES + 1))
		+ HUNT_CYCLES + 64;

	// expected output classes
	localparam int KIND_DATA = 0;
	localparam int KIND_SYNC = 1;
	localparam int KIND_CTRL = 2;
	localparam int KIND_ANY = 3;

	logic hdmi_clk = 1'b0;
	logic reset;
	logic in_valid;
	logic phase_step;
	tmds_word_t d0_in;
	tmds_word_t d1_in;
	tmds_word_t d2_in;
	logic hdmi_valid;
	logic data_valid;
	pixel_t d0;
	pixel_t d1;
	pixel_t d2;
	logic sync_valid;
	sync_t sync;
	logic ctrl_valid;
	terc4_t ctrl;

	int cycle_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int unsigned lcg_state;

	// scoreboard with one entry per strobe
	int exp_due[$];
	int exp_kind[$];
	int exp_a[$];
	int exp_b[$];
	int exp_c[$];

	// transmitter model state with the bit slip and the last symbol per channel
	int bit_slip;
	logic hunting;
	tmds_word_t sent0;
	tmds_word_t sent1;
	tmds_word_t sent2;
	int prev_kind;
	int prev_a;
	int prev_b;
	int prev_c;

	tmds_decoder #(
		.LOCK_TIMEOUT_BITS(LOCK_TIMEOUT_BITS)
	) i_dut (
		.hdmi_clk(hdmi_clk),
		.reset(reset),
		.in_valid(in_valid),
		.phase_step(phase_step),
		.d0_in(d0_in),
		.d1_in(d1_in),
		.d2_in(d2_in),
		.hdmi_valid(hdmi_valid),
		.data_valid(data_valid),
		.d0(d0),
		.d1(d1),
		.d2(d2),
		.sync_valid(sync_valid),
		.sync(sync),
		.ctrl_valid(ctrl_valid),
		.ctrl(ctrl)
	);

	initial
	begin
		forever
			#50 hdmi_clk = ~hdmi_clk;
	end

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
		value_errors++;
	endtask

	task automatic failure(input string what);
		$display("%0t: %s", $time, what);
		other_errors++;
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// running xor or xnor chain followed by optional inversion of the data bits
	function automatic tmds_word_t tmds_encode(pixel_t value, logic invert, logic use_xor);
		pixel_t q;
		q[0] = value[0];
		for (int i = 1; i < 8; i++)
			q[i] = use_xor ? (q[i-1] ^ value[i]) : ~(q[i-1] ^ value[i]);
		return {invert, use_xor, invert ? ~q : q};
	endfunction

	// control and TERC4 symbols are not pixel data
	function automatic logic is_reserved(tmds_word_t w);
		logic hit;
		hit = (w == CTRL_00) || (w == CTRL_01) || (w == CTRL_10) || (w == CTRL_11);
		for (int n = 0; n < 16; n++)
		begin
			if (w == TERC4_CODES[n])
				hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic random_pixel(output pixel_t value, output tmds_word_t word);
		logic [31:0] r;
		do
		begin
			r = lcg_next();
			value = r[7:0];
			word = tmds_encode(value, r[8], r[9]);
		end
		while (is_reserved(word));
	endtask

	// raw word as the deserializer sees it when the stream is slipped by some bits
	function automatic tmds_word_t serial_word(tmds_word_t older, tmds_word_t newer, int slip);
		logic [2*WORD_BITS-1:0] stream;
		stream = {older, newer} >> slip;
		return stream[WORD_BITS-1:0];
	endfunction

	task automatic expect_output(input int kind, input int a, input int b, input int c);
		exp_due.push_back(cycle_count + 2);
		exp_kind.push_back(kind);
		exp_a.push_back(a);
		exp_b.push_back(b);
		exp_c.push_back(c);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge hdmi_clk);
			in_valid = 1'b0;
			phase_step = 1'b0;
		end
	endtask

	task automatic pulse_phase_step();
		@(negedge hdmi_clk);
		in_valid = 1'b0;
		phase_step = 1'b1;
		@(negedge hdmi_clk);
		phase_step = 1'b0;
	endtask

	// one strobe carrying the next transmitted symbol on each channel
	task automatic send_stream(input tmds_word_t s0, input tmds_word_t s1,
		input tmds_word_t s2, input int kind, input int a, input int b, input int c);
		@(negedge hdmi_clk);
		in_valid = 1'b1;
		phase_step = 1'b0;
		d0_in = serial_word(sent0, s0, bit_slip);
		d1_in = serial_word(sent1, s1, bit_slip);
		d2_in = serial_word(sent2, s2, bit_slip);
		// with a slip a symbol is only complete once the next raw word is in
		if (hunting)
			expect_output(KIND_ANY, 0, 0, 0);
		else if (bit_slip == 0)
			expect_output(kind, a, b, c);
		else
			expect_output(prev_kind, prev_a, prev_b, prev_c);
		sent0 = s0;
		sent1 = s1;
		sent2 = s2;
		prev_kind = kind;
		prev_a = a;
		prev_b = b;
		prev_c = c;
	endtask

	task automatic send_pixel();
		pixel_t p0;
		pixel_t p1;
		pixel_t p2;
		tmds_word_t w0;
		tmds_word_t w1;
		tmds_word_t w2;
		random_pixel(p0, w0);
		random_pixel(p1, w1);
		random_pixel(p2, w2);
		send_stream(w0, w1, w2, KIND_DATA, p0, p1, p2);
	endtask

	task automatic check_output();
		int kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [2:0] strobes;
		logic [2:0] want;
		exp_due.delete(0);
		kind = exp_kind.pop_front();
		a = exp_a.pop_front();
		b = exp_b.pop_front();
		c = exp_c.pop_front();
		strobes = {data_valid, sync_valid, ctrl_valid};
		case (kind)
		KIND_DATA: want = 3'b100;
		KIND_SYNC: want = 3'b010;
		KIND_CTRL: want = 3'b001;
		default: want = 3'b000;
		endcase
		if (kind == KIND_ANY)
		begin
			if ($countones(strobes) != 1)
				failure("misaligned symbol did not give exactly one class strobe");
		end
		else if (strobes !== want)
			value_error("{data_valid,sync_valid,ctrl_valid}", strobes, want);
		else if (kind == KIND_DATA)
		begin
			if (d0 !== a[7:0])
				value_error("d0", d0, a);
			if (d1 !== b[7:0])
				value_error("d1", d1, b);
			if (d2 !== c[7:0])
				value_error("d2", d2, c);
		end
		else if (kind == KIND_SYNC)
		begin
			if (sync !== a[1:0])
				value_error("sync", sync, a);
		end
		else if (ctrl !== a[3:0])
			value_error("ctrl", ctrl, a);
	endtask

	// outputs are compared on the falling edge once they have settled
	always @(negedge hdmi_clk)
	begin
		if (exp_due.size() > 0 && exp_due[0] == cycle_count)
			check_output();
		else if (data_valid || sync_valid || ctrl_valid)
			failure("class strobe with no symbol sent two cycles earlier");
	end

	always @(posedge hdmi_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("timeout after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	`include "tmds_tests.svh"

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		phase_step = 1'b0;
		d0_in = '0;
		d1_in = '0;
		d2_in = '0;
		lcg_state = 10;
		bit_slip = 0;
		hunting = 1'b0;
		sent0 = CTRL_11;
		sent1 = CTRL_11;
		sent2 = CTRL_11;
		prev_kind = KIND_SYNC;
		prev_a = 3;
		prev_b = 0;
		prev_c = 0;
		repeat (8) @(negedge hdmi_clk);
		reset = 1'b0;
		check_reset_state();
		lock_at_phase_zero();
		pixel_decode();
		classify_codes();
		alignment_hunt();
		lock_loss();
		idle(4);
		if (exp_due.size() != 0)
			failure("expected outputs never appeared");
		$display("value errors: %0d, other failures: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tmds_decoder.f
common/tmds_pkg.sv
common/tmds_word_if.sv
design/tmds_word_aligner.sv
design/tmds_sync_recognizer.sv
design/tmds_symbol_decoder.sv
design/tmds_decoder.sv
+incdir+verif
verif/tmds_decoder_tb.sv

// File: Bender.yml
package:
  name: tmds_decoder

sources:
  # package and interface ahead of the modules that use them
  - common/tmds_pkg.sv
  - common/tmds_word_if.sv
  - design/tmds_word_aligner.sv
  - design/tmds_sync_recognizer.sv
  - design/tmds_symbol_decoder.sv
  - design/tmds_decoder.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tmds_decoder_tb.sv
